// File: logic/glb_settings.svh
// global buffer sizing, shared by RTL and testbench
// GLB_ADDR_WIDTH must equal tile field + word field + byte offset bits
`ifndef GLB_SETTINGS_SVH
`define GLB_SETTINGS_SVH

// tiles in the eastward chain
`define GLB_NUM_TILES 4

// bank word and depth
`define GLB_BANK_DATA_WIDTH 64
`define GLB_BANK_ADDR_WIDTH 8

// tile field, top bits of both processor and config addresses
`define GLB_TILE_SEL_WIDTH 2

// processor byte address: tile | word | 3-bit byte offset
`define GLB_ADDR_WIDTH 13

// config space, one register per tile at offset 0
`define GLB_CFG_ADDR_WIDTH 16
`define GLB_CFG_DATA_WIDTH 32

`endif

// File: logic/global_buffer_pkg.sv
// vector types for the global buffer
// widths come from glb_settings.svh
`default_nettype none

`include "glb_settings.svh"

package global_buffer_pkg;

    // one bank word and its byte strobes
    typedef logic [`GLB_BANK_DATA_WIDTH-1:0]   bank_data_t;
    typedef logic [`GLB_BANK_DATA_WIDTH/8-1:0] bank_strb_t;

    // processor byte address
    typedef logic [`GLB_ADDR_WIDTH-1:0]        glb_addr_t;

    // word index inside one bank
    typedef logic [`GLB_BANK_ADDR_WIDTH-1:0]   bank_addr_t;

    // tile number in the chain
    typedef logic [`GLB_TILE_SEL_WIDTH-1:0]    tile_id_t;

    // configuration port
    typedef logic [`GLB_CFG_ADDR_WIDTH-1:0]    cfg_addr_t;
    typedef logic [`GLB_CFG_DATA_WIDTH-1:0]    cfg_data_t;

endpackage

`default_nettype wire

// File: logic/glb_dummy_start.sv
// west end of the tile chain, no handshake and no back-pressure
// config write and read must never be requested in the same cycle
`timescale 1ns/10ps
`default_nettype none

module glb_dummy_start import global_buffer_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,

    // processor requests
    input  logic        proc2glb_wr_en,
    input  bank_strb_t  proc2glb_wr_strb,
    input  glb_addr_t   proc2glb_wr_addr,
    input  bank_data_t  proc2glb_wr_data,
    input  logic        proc2glb_rd_en,
    input  glb_addr_t   proc2glb_rd_addr,
    output bank_data_t  glb2proc_rd_data,
    output logic        glb2proc_rd_data_valid,

    // config requests
    input  logic        glb_cfg_wr_en,
    input  cfg_addr_t   glb_cfg_wr_addr,
    input  cfg_data_t   glb_cfg_wr_data,
    input  logic        glb_cfg_rd_en,
    input  cfg_addr_t   glb_cfg_rd_addr,
    output cfg_data_t   glb_cfg_rd_data,
    output logic        glb_cfg_rd_data_valid,

    // stage 0 packet, eastward
    output logic        out_pkt_wr_en,
    output bank_strb_t  out_pkt_wr_strb,
    output glb_addr_t   out_pkt_wr_addr,
    output bank_data_t  out_pkt_wr_data,
    output logic        out_pkt_rd_en,
    output glb_addr_t   out_pkt_rd_addr,
    output logic        out_cfg_wr_en,
    output logic        out_cfg_rd_en,
    output cfg_addr_t   out_cfg_addr,
    output cfg_data_t   out_cfg_wr_data,
    output logic        out_rs_valid,
    output bank_data_t  out_rs_data,
    output logic        out_cfg_rs_valid,
    output cfg_data_t   out_cfg_rs_data,

    // responses back from the last tile
    input  logic        ret_rs_valid,
    input  bank_data_t  ret_rs_data,
    input  logic        ret_cfg_rs_valid,
    input  cfg_data_t   ret_cfg_rs_data
);

    // request strobes
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_pkt_wr_en <= 1'b0;
            out_pkt_rd_en <= 1'b0;
            out_cfg_wr_en <= 1'b0;
            out_cfg_rd_en <= 1'b0;
        end else begin
            out_pkt_wr_en <= proc2glb_wr_en;
            out_pkt_rd_en <= proc2glb_rd_en;
            out_cfg_wr_en <= glb_cfg_wr_en;
            out_cfg_rd_en <= glb_cfg_rd_en;
        end
    end

    // payload fields, meaningful only with their strobe
    always_ff @(posedge clk) begin
        out_pkt_wr_strb <= proc2glb_wr_strb;
        out_pkt_wr_addr <= proc2glb_wr_addr;
        out_pkt_wr_data <= proc2glb_wr_data;
        out_pkt_rd_addr <= proc2glb_rd_addr;
        // one shared config address, the strobes are exclusive
        out_cfg_addr    <= glb_cfg_rd_en ? glb_cfg_rd_addr : glb_cfg_wr_addr;
        out_cfg_wr_data <= glb_cfg_wr_data;
    end

    // chain starts with empty response slots
    assign out_rs_valid     = 1'b0;
    assign out_rs_data      = '0;
    assign out_cfg_rs_valid = 1'b0;
    assign out_cfg_rs_data  = '0;

    // returning responses straight to the outside
    assign glb2proc_rd_data       = ret_rs_data;
    assign glb2proc_rd_data_valid = ret_rs_valid;
    assign glb_cfg_rd_data        = ret_cfg_rs_data;
    assign glb_cfg_rd_data_valid  = ret_cfg_rs_valid;

    // the packet carries a single config address
    cfg_excl_a: assert property (@(posedge clk) disable iff (!rst_n)
        !(glb_cfg_wr_en && glb_cfg_rd_en))
        else $error("config write and read requested in the same cycle");

endmodule

`default_nettype wire

// File: logic/glb_tile_decode.sv
// address decode for one tile, purely combinational
// config space holds only register 0 per tile
`timescale 1ns/10ps
`default_nettype none

`include "glb_settings.svh"

module glb_tile_decode import global_buffer_pkg::*; #(
    parameter int TILE_ID = 0
) (
    input  logic        in_pkt_wr_en,
    input  bank_strb_t  in_pkt_wr_strb,
    input  glb_addr_t   in_pkt_wr_addr,
    input  logic        in_pkt_rd_en,
    input  glb_addr_t   in_pkt_rd_addr,
    input  logic        in_cfg_wr_en,
    input  logic        in_cfg_rd_en,
    input  cfg_addr_t   in_cfg_addr,
    input  logic        lock,

    output logic        bank_wr_en,
    output logic        bank_rd_en,
    output bank_addr_t  bank_wr_addr,
    output bank_addr_t  bank_rd_addr,
    output bank_strb_t  bank_strb,
    output logic        cfg_wr_hit,
    output logic        cfg_rd_hit
);

    // bits below the word index
    localparam int BYTE_OFS = $clog2(`GLB_BANK_DATA_WIDTH / 8);
    localparam int CFG_REG_W = `GLB_CFG_ADDR_WIDTH - `GLB_TILE_SEL_WIDTH;

    tile_id_t wr_tile;
    tile_id_t rd_tile;
    tile_id_t cfg_tile;
    logic     cfg_reg0;

    // tile fields sit at the top of each address
    assign wr_tile  = in_pkt_wr_addr[`GLB_ADDR_WIDTH-1 -: `GLB_TILE_SEL_WIDTH];
    assign rd_tile  = in_pkt_rd_addr[`GLB_ADDR_WIDTH-1 -: `GLB_TILE_SEL_WIDTH];
    assign cfg_tile = in_cfg_addr[`GLB_CFG_ADDR_WIDTH-1 -: `GLB_TILE_SEL_WIDTH];
    assign cfg_reg0 = (in_cfg_addr[CFG_REG_W-1:0] == '0);

    // locked tile drops processor writes
    assign bank_wr_en = in_pkt_wr_en && (wr_tile == tile_id_t'(TILE_ID)) && !lock;
    assign bank_rd_en = in_pkt_rd_en && (rd_tile == tile_id_t'(TILE_ID));

    // word index, byte offset dropped
    assign bank_wr_addr = in_pkt_wr_addr[BYTE_OFS +: `GLB_BANK_ADDR_WIDTH];
    assign bank_rd_addr = in_pkt_rd_addr[BYTE_OFS +: `GLB_BANK_ADDR_WIDTH];
    assign bank_strb    = in_pkt_wr_strb;

    // lock register hits
    assign cfg_wr_hit = in_cfg_wr_en && (cfg_tile == tile_id_t'(TILE_ID)) && cfg_reg0;
    assign cfg_rd_hit = in_cfg_rd_en && (cfg_tile == tile_id_t'(TILE_ID)) && cfg_reg0;

endmodule

`default_nettype wire

// File: logic/glb_bank.sv
// single word array with byte strobes and a registered read
// read and write in one cycle return the old word
`timescale 1ns/10ps
`default_nettype none

`include "glb_settings.svh"

module glb_bank #(
    parameter int ADDR_WIDTH = `GLB_BANK_ADDR_WIDTH
) (
    input  logic                              clk,
    input  logic                              wr_en,
    input  logic                              rd_en,
    input  logic [ADDR_WIDTH-1:0]             wr_addr,
    input  logic [ADDR_WIDTH-1:0]             rd_addr,
    input  logic [`GLB_BANK_DATA_WIDTH/8-1:0] strb,
    input  logic [`GLB_BANK_DATA_WIDTH-1:0]   wr_data,
    output logic [`GLB_BANK_DATA_WIDTH-1:0]   rd_data
);

    localparam int NUM_BYTES = `GLB_BANK_DATA_WIDTH / 8;

    // contents undefined after reset
    logic [`GLB_BANK_DATA_WIDTH-1:0] mem [2**ADDR_WIDTH];

    // per-byte write
    always_ff @(posedge clk) begin
        if (wr_en) begin
            for (int b = 0; b < NUM_BYTES; b++) begin
                if (strb[b]) begin
                    mem[wr_addr][b*8 +: 8] <= wr_data[b*8 +: 8];
                end
            end
        end
    end

    // read sees the word before this edge's write
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

`default_nettype wire

// File: logic/glb_tile_result.sv
// packet register of one tile plus its lock register
// bank data joins the response after the register, so the tile stays one cycle
`timescale 1ns/10ps
`default_nettype none

`include "glb_settings.svh"

module glb_tile_result import global_buffer_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,

    // packet from the west
    input  logic        in_pkt_wr_en,
    input  bank_strb_t  in_pkt_wr_strb,
    input  glb_addr_t   in_pkt_wr_addr,
    input  bank_data_t  in_pkt_wr_data,
    input  logic        in_pkt_rd_en,
    input  glb_addr_t   in_pkt_rd_addr,
    input  logic        in_cfg_wr_en,
    input  logic        in_cfg_rd_en,
    input  cfg_addr_t   in_cfg_addr,
    input  cfg_data_t   in_cfg_wr_data,
    input  logic        in_rs_valid,
    input  bank_data_t  in_rs_data,
    input  logic        in_cfg_rs_valid,
    input  cfg_data_t   in_cfg_rs_data,

    // local hits
    input  logic        cfg_wr_hit,
    input  logic        cfg_rd_hit,
    input  logic        bank_rd_en,
    input  bank_data_t  bank_rd_data,

    // packet to the east
    output logic        out_pkt_wr_en,
    output bank_strb_t  out_pkt_wr_strb,
    output glb_addr_t   out_pkt_wr_addr,
    output bank_data_t  out_pkt_wr_data,
    output logic        out_pkt_rd_en,
    output glb_addr_t   out_pkt_rd_addr,
    output logic        out_cfg_wr_en,
    output logic        out_cfg_rd_en,
    output cfg_addr_t   out_cfg_addr,
    output cfg_data_t   out_cfg_wr_data,
    output logic        out_rs_valid,
    output bank_data_t  out_rs_data,
    output logic        out_cfg_rs_valid,
    output cfg_data_t   out_cfg_rs_data,

    output logic        lock
);

    // set when this tile owns the next bank response
    logic       rd_hit_q;
    bank_data_t rs_data_q;

    // strobes, valids and the lock bit
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_pkt_wr_en    <= 1'b0;
            out_pkt_rd_en    <= 1'b0;
            out_cfg_wr_en    <= 1'b0;
            out_cfg_rd_en    <= 1'b0;
            out_rs_valid     <= 1'b0;
            out_cfg_rs_valid <= 1'b0;
            rd_hit_q         <= 1'b0;
            lock             <= 1'b0;
        end else begin
            out_pkt_wr_en    <= in_pkt_wr_en;
            out_pkt_rd_en    <= in_pkt_rd_en;
            out_cfg_wr_en    <= in_cfg_wr_en;
            out_cfg_rd_en    <= in_cfg_rd_en;
            out_rs_valid     <= in_rs_valid || bank_rd_en;
            out_cfg_rs_valid <= in_cfg_rs_valid || cfg_rd_hit;
            rd_hit_q         <= bank_rd_en;
            // only bit 0 is implemented
            if (cfg_wr_hit) begin
                lock <= in_cfg_wr_data[0];
            end
        end
    end

    // payload passes east unchanged
    always_ff @(posedge clk) begin
        out_pkt_wr_strb <= in_pkt_wr_strb;
        out_pkt_wr_addr <= in_pkt_wr_addr;
        out_pkt_wr_data <= in_pkt_wr_data;
        out_pkt_rd_addr <= in_pkt_rd_addr;
        out_cfg_addr    <= in_cfg_addr;
        out_cfg_wr_data <= in_cfg_wr_data;
        rs_data_q       <= in_rs_data;
        // lock value as seen before any write in this packet
        if (cfg_rd_hit) begin
            out_cfg_rs_data <= {{(`GLB_CFG_DATA_WIDTH-1){1'b0}}, lock};
        end else begin
            out_cfg_rs_data <= in_cfg_rs_data;
        end
    end

    // bank word arrives together with the registered packet
    assign out_rs_data = rd_hit_q ? bank_rd_data : rs_data_q;

    // the tile fields are unique, so a slot is filled at most once
    slot_free_a: assert property (@(posedge clk) disable iff (!rst_n)
        !(bank_rd_en && in_rs_valid) && !(cfg_rd_hit && in_cfg_rs_valid))
        else $error("tile hit on a response slot that is already valid");

endmodule

`default_nettype wire

// File: logic/glb_top.sv
// global buffer: start block and a chain of GLB_NUM_TILES tiles
// every read takes the same path, so responses come back in order
`timescale 1ns/10ps
`default_nettype none

`include "glb_settings.svh"

module glb_top import global_buffer_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,

    input  logic        proc2glb_wr_en,
    input  bank_strb_t  proc2glb_wr_strb,
    input  glb_addr_t   proc2glb_wr_addr,
    input  bank_data_t  proc2glb_wr_data,
    input  logic        proc2glb_rd_en,
    input  glb_addr_t   proc2glb_rd_addr,
    output bank_data_t  glb2proc_rd_data,
    output logic        glb2proc_rd_data_valid,

    input  logic        glb_cfg_wr_en,
    input  cfg_addr_t   glb_cfg_wr_addr,
    input  cfg_data_t   glb_cfg_wr_data,
    input  logic        glb_cfg_rd_en,
    input  cfg_addr_t   glb_cfg_rd_addr,
    output cfg_data_t   glb_cfg_rd_data,
    output logic        glb_cfg_rd_data_valid
);

    localparam int NT = `GLB_NUM_TILES;

    // packet at each stage, index 0 from the start block
    logic       pkt_wr_en   [0:NT];
    bank_strb_t pkt_wr_strb [0:NT];
    glb_addr_t  pkt_wr_addr [0:NT];
    bank_data_t pkt_wr_data [0:NT];
    logic       pkt_rd_en   [0:NT];
    glb_addr_t  pkt_rd_addr [0:NT];
    logic       cfg_wr_en   [0:NT];
    logic       cfg_rd_en   [0:NT];
    cfg_addr_t  cfg_addr    [0:NT];
    cfg_data_t  cfg_wr_data [0:NT];
    logic       rs_valid    [0:NT];
    bank_data_t rs_data     [0:NT];
    logic       cfg_rs_valid[0:NT];
    cfg_data_t  cfg_rs_data [0:NT];

    glb_dummy_start u_start (
        .clk, .rst_n,
        .proc2glb_wr_en, .proc2glb_wr_strb, .proc2glb_wr_addr, .proc2glb_wr_data,
        .proc2glb_rd_en, .proc2glb_rd_addr,
        .glb2proc_rd_data, .glb2proc_rd_data_valid,
        .glb_cfg_wr_en, .glb_cfg_wr_addr, .glb_cfg_wr_data,
        .glb_cfg_rd_en, .glb_cfg_rd_addr,
        .glb_cfg_rd_data, .glb_cfg_rd_data_valid,
        .out_pkt_wr_en    (pkt_wr_en[0]),
        .out_pkt_wr_strb  (pkt_wr_strb[0]),
        .out_pkt_wr_addr  (pkt_wr_addr[0]),
        .out_pkt_wr_data  (pkt_wr_data[0]),
        .out_pkt_rd_en    (pkt_rd_en[0]),
        .out_pkt_rd_addr  (pkt_rd_addr[0]),
        .out_cfg_wr_en    (cfg_wr_en[0]),
        .out_cfg_rd_en    (cfg_rd_en[0]),
        .out_cfg_addr     (cfg_addr[0]),
        .out_cfg_wr_data  (cfg_wr_data[0]),
        .out_rs_valid     (rs_valid[0]),
        .out_rs_data      (rs_data[0]),
        .out_cfg_rs_valid (cfg_rs_valid[0]),
        .out_cfg_rs_data  (cfg_rs_data[0]),
        // last tile feeds the responses back
        .ret_rs_valid     (rs_valid[NT]),
        .ret_rs_data      (rs_data[NT]),
        .ret_cfg_rs_valid (cfg_rs_valid[NT]),
        .ret_cfg_rs_data  (cfg_rs_data[NT])
    );

    for (genvar t = 0; t < NT; t++) begin : g_tile
        logic       bank_wr_en;
        logic       bank_rd_en;
        bank_addr_t bank_wr_addr;
        bank_addr_t bank_rd_addr;
        bank_strb_t bank_strb;
        bank_data_t bank_rd_data;
        logic       cfg_wr_hit;
        logic       cfg_rd_hit;
        logic       lock;

        glb_tile_decode #(.TILE_ID(t)) u_decode (
            .in_pkt_wr_en   (pkt_wr_en[t]),
            .in_pkt_wr_strb (pkt_wr_strb[t]),
            .in_pkt_wr_addr (pkt_wr_addr[t]),
            .in_pkt_rd_en   (pkt_rd_en[t]),
            .in_pkt_rd_addr (pkt_rd_addr[t]),
            .in_cfg_wr_en   (cfg_wr_en[t]),
            .in_cfg_rd_en   (cfg_rd_en[t]),
            .in_cfg_addr    (cfg_addr[t]),
            .lock, .bank_wr_en, .bank_rd_en, .bank_wr_addr, .bank_rd_addr,
            .bank_strb, .cfg_wr_hit, .cfg_rd_hit
        );

        glb_bank #(.ADDR_WIDTH(`GLB_BANK_ADDR_WIDTH)) u_bank (
            .clk,
            .wr_en   (bank_wr_en),
            .rd_en   (bank_rd_en),
            .wr_addr (bank_wr_addr),
            .rd_addr (bank_rd_addr),
            .strb    (bank_strb),
            .wr_data (pkt_wr_data[t]),
            .rd_data (bank_rd_data)
        );

        glb_tile_result u_result (
            .clk, .rst_n,
            .in_pkt_wr_en    (pkt_wr_en[t]),
            .in_pkt_wr_strb  (pkt_wr_strb[t]),
            .in_pkt_wr_addr  (pkt_wr_addr[t]),
            .in_pkt_wr_data  (pkt_wr_data[t]),
            .in_pkt_rd_en    (pkt_rd_en[t]),
            .in_pkt_rd_addr  (pkt_rd_addr[t]),
            .in_cfg_wr_en    (cfg_wr_en[t]),
            .in_cfg_rd_en    (cfg_rd_en[t]),
            .in_cfg_addr     (cfg_addr[t]),
            .in_cfg_wr_data  (cfg_wr_data[t]),
            .in_rs_valid     (rs_valid[t]),
            .in_rs_data      (rs_data[t]),
            .in_cfg_rs_valid (cfg_rs_valid[t]),
            .in_cfg_rs_data  (cfg_rs_data[t]),
            .cfg_wr_hit, .cfg_rd_hit, .bank_rd_en, .bank_rd_data,
            .out_pkt_wr_en   (pkt_wr_en[t+1]),
            .out_pkt_wr_strb (pkt_wr_strb[t+1]),
            .out_pkt_wr_addr (pkt_wr_addr[t+1]),
            .out_pkt_wr_data (pkt_wr_data[t+1]),
            .out_pkt_rd_en   (pkt_rd_en[t+1]),
            .out_pkt_rd_addr (pkt_rd_addr[t+1]),
            .out_cfg_wr_en   (cfg_wr_en[t+1]),
            .out_cfg_rd_en   (cfg_rd_en[t+1]),
            .out_cfg_addr    (cfg_addr[t+1]),
            .out_cfg_wr_data (cfg_wr_data[t+1]),
            .out_rs_valid    (rs_valid[t+1]),
            .out_rs_data     (rs_data[t+1]),
            .out_cfg_rs_valid(cfg_rs_valid[t+1]),
            .out_cfg_rs_data (cfg_rs_data[t+1]),
            .lock
        );
    end

endmodule

`default_nettype wire

// File: tests/glb_tb_clock.sv
// free-running testbench clock and active-low reset
// reset releases on a falling edge after RESET_CYCLES rising edges
`timescale 1ns/10ps
`default_nettype none

module glb_tb_clock #(
    parameter int PERIOD_NS    = 4,
    parameter int RESET_CYCLES = 4
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // release away from the rising edge
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

`default_nettype wire

// File: tests/glb_tb.sv
// directed tests for glb_top, inputs driven and outputs sampled on the falling edge
// reads only touch words written earlier, bank contents start undefined
`timescale 1ns/10ps
`default_nettype none

`include "glb_settings.svh"

module glb_tb import global_buffer_pkg::*; ();

    localparam int NT              = `GLB_NUM_TILES;
    localparam int CLK_PERIOD_NS   = 4;
    localparam int RESET_CYCLES    = 4;
    localparam int WATCHDOG_CYCLES = 2000;

    logic       clk;
    logic       rst_n;
    logic       proc2glb_wr_en;
    bank_strb_t proc2glb_wr_strb;
    glb_addr_t  proc2glb_wr_addr;
    bank_data_t proc2glb_wr_data;
    logic       proc2glb_rd_en;
    glb_addr_t  proc2glb_rd_addr;
    bank_data_t glb2proc_rd_data;
    logic       glb2proc_rd_data_valid;
    logic       glb_cfg_wr_en;
    cfg_addr_t  glb_cfg_wr_addr;
    cfg_data_t  glb_cfg_wr_data;
    logic       glb_cfg_rd_en;
    cfg_addr_t  glb_cfg_rd_addr;
    cfg_data_t  glb_cfg_rd_data;
    logic       glb_cfg_rd_data_valid;

    // reference model
    bank_data_t model_mem  [NT][2**`GLB_BANK_ADDR_WIDTH];
    logic       model_lock [NT];
    bank_data_t exp_rd_q[$];
    int unsigned exp_rd_cyc_q[$];
    cfg_data_t  exp_cfg_q[$];
    int unsigned exp_cfg_cyc_q[$];

    // word indices used by every test, spread over the bank
    bank_addr_t test_words [4] = '{8'h00, 8'h3c, 8'h81, 8'hff};

    logic [31:0] rng = 32'd31399;
    int unsigned cyc = 0;
    int data_errs  = 0;
    int lat_errs   = 0;
    int proto_errs = 0;

    glb_tb_clock #(.PERIOD_NS(CLK_PERIOD_NS), .RESET_CYCLES(RESET_CYCLES)) u_clock (
        .clk, .rst_n
    );

    glb_top i_dut (.*);

    // rising edges so far, stable when read on the falling edge
    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_rand();
        rng = xorshift32(rng);
        return rng;
    endfunction

    function automatic bank_data_t next_word();
        logic [31:0] hi;
        hi = next_rand();
        return {hi, next_rand()};
    endfunction

    // tile | word | byte offset 0
    function automatic glb_addr_t proc_addr(input tile_id_t t, input bank_addr_t w);
        return {t, w, 3'b000};
    endfunction

    // register 0 of a tile
    function automatic cfg_addr_t cfg_addr(input tile_id_t t);
        return {t, {(`GLB_CFG_ADDR_WIDTH-`GLB_TILE_SEL_WIDTH){1'b0}}};
    endfunction

    function automatic bank_data_t byte_merge(input bank_data_t old_w, input bank_data_t new_w,
                                              input bank_strb_t strb);
        bank_data_t res;
        res = old_w;
        for (int b = 0; b < `GLB_BANK_DATA_WIDTH/8; b++) begin
            if (strb[b]) res[b*8 +: 8] = new_w[b*8 +: 8];
        end
        return res;
    endfunction

    task automatic check_rd_data(input bank_data_t exp, input bank_data_t got);
        if (got !== exp) begin
            $display("FAILED glb2proc_rd_data expected %h got %h", exp, got);
            data_errs++;
        end
    endtask

    task automatic check_cfg_data(input cfg_data_t exp, input cfg_data_t got);
        if (got !== exp) begin
            $display("FAILED glb_cfg_rd_data expected %h got %h", exp, got);
            data_errs++;
        end
    endtask

    task automatic check_latency(input string what, input int unsigned issued);
        if (cyc - issued != NT + 1) begin
            $display("%s response came %0d cycles after its request instead of %0d",
                     what, cyc - issued, NT + 1);
            lat_errs++;
        end
    endtask

    // response monitor, pops in issue order
    always @(negedge clk) begin
        if (rst_n && glb2proc_rd_data_valid) begin
            if (exp_rd_q.size() == 0) begin
                $display("unexpected read response with no read outstanding");
                proto_errs++;
            end else begin
                check_rd_data(exp_rd_q.pop_front(), glb2proc_rd_data);
                check_latency("read", exp_rd_cyc_q.pop_front());
            end
        end
        if (rst_n && glb_cfg_rd_data_valid) begin
            if (exp_cfg_q.size() == 0) begin
                $display("unexpected config response with no config read outstanding");
                proto_errs++;
            end else begin
                check_cfg_data(exp_cfg_q.pop_front(), glb_cfg_rd_data);
                check_latency("config", exp_cfg_cyc_q.pop_front());
            end
        end
    end

    // one processor cycle, the read sees the model before this cycle's write
    task automatic proc_cycle(input logic wr, input bank_strb_t strb, input tile_id_t wt,
                              input bank_addr_t ww, input bank_data_t wdata,
                              input logic rd, input tile_id_t rt, input bank_addr_t rw);
        @(negedge clk);
        proc2glb_wr_en   = wr;
        proc2glb_wr_strb = strb;
        proc2glb_wr_addr = proc_addr(wt, ww);
        proc2glb_wr_data = wdata;
        proc2glb_rd_en   = rd;
        proc2glb_rd_addr = proc_addr(rt, rw);
        glb_cfg_wr_en    = 1'b0;
        glb_cfg_rd_en    = 1'b0;
        if (rd) begin
            exp_rd_q.push_back(model_mem[rt][rw]);
            exp_rd_cyc_q.push_back(cyc);
        end
        if (wr && !model_lock[wt]) begin
            model_mem[wt][ww] = byte_merge(model_mem[wt][ww], wdata, strb);
        end
    endtask

    task automatic cfg_write(input tile_id_t t, input cfg_data_t data);
        @(negedge clk);
        proc2glb_wr_en  = 1'b0;
        proc2glb_rd_en  = 1'b0;
        glb_cfg_wr_en   = 1'b1;
        glb_cfg_wr_addr = cfg_addr(t);
        glb_cfg_wr_data = data;
        glb_cfg_rd_en   = 1'b0;
        // lock is bit 0 only
        model_lock[t] = data[0];
    endtask

    task automatic cfg_read(input tile_id_t t);
        @(negedge clk);
        proc2glb_wr_en  = 1'b0;
        proc2glb_rd_en  = 1'b0;
        glb_cfg_wr_en   = 1'b0;
        glb_cfg_rd_en   = 1'b1;
        glb_cfg_rd_addr = cfg_addr(t);
        exp_cfg_q.push_back(cfg_data_t'(model_lock[t]));
        exp_cfg_cyc_q.push_back(cyc);
    endtask

    task automatic idle_cycle();
        @(negedge clk);
        proc2glb_wr_en = 1'b0;
        proc2glb_rd_en = 1'b0;
        glb_cfg_wr_en  = 1'b0;
        glb_cfg_rd_en  = 1'b0;
    endtask

    // watchdog catches responses that never come
    task automatic wait_drain();
        idle_cycle();
        while (exp_rd_q.size() != 0 || exp_cfg_q.size() != 0) begin
            @(negedge clk);
        end
        repeat (2) @(negedge clk);
    endtask

    task automatic test_reset();
        repeat (RESET_CYCLES + 8) begin
            @(negedge clk);
            if (glb2proc_rd_data_valid !== 1'b0 || glb_cfg_rd_data_valid !== 1'b0) begin
                $display("response valid raised before any read was issued");
                proto_errs++;
            end
        end
    endtask

    // every tile, every test word
    task automatic test_full_writes();
        for (int t = 0; t < NT; t++) begin
            for (int i = 0; i < 4; i++) begin
                proc_cycle(1'b1, '1, tile_id_t'(t), test_words[i], next_word(), 1'b0, '0, '0);
            end
        end
        for (int t = 0; t < NT; t++) begin
            for (int i = 0; i < 4; i++) begin
                proc_cycle(1'b0, '0, '0, '0, '0, 1'b1, tile_id_t'(t), test_words[i]);
            end
        end
        wait_drain();
    endtask

    task automatic test_partial_strobes();
        bank_strb_t strb;
        proc_cycle(1'b1, '1, 2'd3, test_words[1], 64'h0123_4567_89ab_cdef, 1'b0, '0, '0);
        for (int i = 0; i < 8; i++) begin
            strb = bank_strb_t'(next_rand());
            proc_cycle(1'b1, strb, 2'd3, test_words[1], next_word(), 1'b0, '0, '0);
            proc_cycle(1'b0, '0, '0, '0, '0, 1'b1, 2'd3, test_words[1]);
        end
        wait_drain();
    endtask

    // one read per cycle, writes mixed in, same-address hits included
    task automatic test_mixed_stream();
        logic [31:0] r;
        tile_id_t    wt;
        bank_addr_t  ww;
        bank_strb_t  strb;
        for (int i = 0; i < 40; i++) begin
            r    = next_rand();
            wt   = tile_id_t'(r[3:2]);
            ww   = test_words[r[5:4]];
            strb = r[1] ? '1 : bank_strb_t'(r[15:8]);
            if (r[18]) begin
                proc_cycle(r[0], strb, wt, ww, next_word(), 1'b1, wt, ww);
            end else begin
                proc_cycle(r[0], strb, wt, ww, next_word(), 1'b1,
                           tile_id_t'(r[7:6]), test_words[r[17:16]]);
            end
        end
        wait_drain();
    endtask

    task automatic test_lock();
        cfg_write(2'd2, 32'h0000_0001);
        cfg_read(2'd2);
        cfg_read(2'd1);
        // tile 2 locked, tile 1 open
        proc_cycle(1'b1, '1, 2'd2, test_words[0], next_word(), 1'b0, '0, '0);
        proc_cycle(1'b1, '1, 2'd1, test_words[0], next_word(), 1'b0, '0, '0);
        proc_cycle(1'b1, 8'h0f, 2'd2, test_words[3], next_word(), 1'b1, 2'd2, test_words[0]);
        proc_cycle(1'b0, '0, '0, '0, '0, 1'b1, 2'd1, test_words[0]);
        proc_cycle(1'b0, '0, '0, '0, '0, 1'b1, 2'd2, test_words[3]);
        wait_drain();
        // upper bits set, bit 0 clear
        cfg_write(2'd2, 32'hffff_fffe);
        cfg_read(2'd2);
        proc_cycle(1'b1, '1, 2'd2, test_words[0], next_word(), 1'b0, '0, '0);
        proc_cycle(1'b0, '0, '0, '0, '0, 1'b1, 2'd2, test_words[0]);
        wait_drain();
    endtask

    // budget well above the longest test sequence
    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD_NS);
        $display("watchdog expired after %0d cycles, responses still outstanding",
                 WATCHDOG_CYCLES);
        $display("Test failed");
        $finish;
    end

    initial begin
        proc2glb_wr_en   = 1'b0;
        proc2glb_wr_strb = '0;
        proc2glb_wr_addr = '0;
        proc2glb_wr_data = '0;
        proc2glb_rd_en   = 1'b0;
        proc2glb_rd_addr = '0;
        glb_cfg_wr_en    = 1'b0;
        glb_cfg_wr_addr  = '0;
        glb_cfg_wr_data  = '0;
        glb_cfg_rd_en    = 1'b0;
        glb_cfg_rd_addr  = '0;
        for (int t = 0; t < NT; t++) model_lock[t] = 1'b0;

        test_reset();
        test_full_writes();
        test_partial_strobes();
        test_mixed_stream();
        test_lock();

        $display("errors: data %0d, latency %0d, protocol %0d", data_errs, lat_errs, proto_errs);
        if (data_errs + lat_errs + proto_errs == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+logic
logic/global_buffer_pkg.sv
logic/glb_dummy_start.sv
logic/glb_tile_decode.sv
logic/glb_bank.sv
logic/glb_tile_result.sv
logic/glb_top.sv
tests/glb_tb_clock.sv
tests/glb_tb.sv

// File: run_sim.sh
#!/bin/sh
# build glb_tb with Verilator and run it; exit status follows the test outcome
cd "$(dirname "$0")" &&
verilator --binary --timing -j 0 -f verilog.f --top-module glb_tb -o glb_sim &&
./obj_dir/glb_sim | tee /dev/stderr | grep -q "Test completed successfully" || exit 1
